/* switch_pkg.sv */
`default_nettype none

package switch_pkg;

    // ****************************************
    // Switch geometry
    // ****************************************
    localparam int N_PORTS   = 4;
    localparam int PORT_W    = 2;
    localparam int VOQ_DEPTH = 4;

    // Every VOQ can be full at once without draining the free list.
    localparam int BUF_DEPTH = N_PORTS * VOQ_DEPTH;
    localparam int ADDR_W    = 4;
    localparam int DATA_W    = 32;

    // ****************************************
    // Register map
    // ****************************************
    localparam int CNT_W      = 16;
    localparam int CSR_ADDR_W = 3;

    localparam logic [CSR_ADDR_W-1:0] CSR_ENABLE    = 3'd0;
    // Drop counters of ports 1 to 3 follow this one.
    localparam logic [CSR_ADDR_W-1:0] CSR_DROP_BASE = 3'd4;

endpackage

`default_nettype wire

/* voq.sv */
`default_nettype none

module voq (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           write_req_i,
    input  wire logic [switch_pkg::ADDR_W-1:0]  ptr_i,
    input  wire logic                           read_req_i,
    output logic      [switch_pkg::ADDR_W-1:0]  ptr_o,
    output logic                                ptr_valid_o,
    output logic                                empty_o,
    output logic                                full_o
);

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_NORMAL,
        ST_FULL
    } state_t;

    state_t state;

    logic [$clog2(switch_pkg::VOQ_DEPTH)-1:0] rd_idx;
    logic [$clog2(switch_pkg::VOQ_DEPTH)-1:0] wr_idx;
    logic [$clog2(switch_pkg::VOQ_DEPTH)-1:0] rd_idx_nxt;
    logic [$clog2(switch_pkg::VOQ_DEPTH)-1:0] wr_idx_nxt;
    logic [switch_pkg::ADDR_W-1:0]            ptr_table [switch_pkg::VOQ_DEPTH];

    logic bypass;
    logic push;
    logic pop;

    assign empty_o = (state == ST_EMPTY);
    assign full_o  = (state == ST_FULL);

    assign rd_idx_nxt = rd_idx + 1'b1;
    assign wr_idx_nxt = wr_idx + 1'b1;

    // A pointer written into an empty queue while it is read goes straight out.
    assign bypass = empty_o && write_req_i && read_req_i;
    assign push   = write_req_i && !bypass && (!full_o || read_req_i);
    assign pop    = read_req_i && !empty_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_EMPTY;
            rd_idx      <= '0;
            wr_idx      <= '0;
            ptr_valid_o <= 1'b0;
        end else begin
            ptr_valid_o <= bypass || pop;
            if (push) begin
                wr_idx <= wr_idx_nxt;
            end
            if (pop) begin
                rd_idx <= rd_idx_nxt;
            end
            case (state)
                ST_EMPTY: begin
                    if (push) begin
                        state <= ST_NORMAL;
                    end
                end
                ST_NORMAL: begin
                    if (push && !pop && wr_idx_nxt == rd_idx) begin
                        state <= ST_FULL;
                    end else if (pop && !push && rd_idx_nxt == wr_idx) begin
                        state <= ST_EMPTY;
                    end
                end
                ST_FULL: begin
                    if (pop && !push) begin
                        state <= ST_NORMAL;
                    end
                end
                default: state <= ST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ptr_table[wr_idx] <= ptr_i;
        end
        if (bypass) begin
            ptr_o <= ptr_i;
        end else if (pop) begin
            ptr_o <= ptr_table[rd_idx];
        end
    end

    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (read_req_i && empty_o) |-> write_req_i);

    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        (write_req_i && full_o) |-> read_req_i);

endmodule

`default_nettype wire

/* free_list.sv */
`default_nettype none

module free_list (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           alloc_i,
    output logic      [switch_pkg::ADDR_W-1:0]  alloc_addr_o,
    input  wire logic                           free_i,
    input  wire logic [switch_pkg::ADDR_W-1:0]  free_addr_i,
    output logic                                empty_o
);

    // Circular FIFO of unused buffer addresses. Head and tail wrap at BUF_DEPTH.
    logic [switch_pkg::ADDR_W-1:0] pool [switch_pkg::BUF_DEPTH];
    logic [switch_pkg::ADDR_W-1:0] head_q;
    logic [switch_pkg::ADDR_W-1:0] tail_q;
    logic [switch_pkg::ADDR_W:0]   count_q;

    assign alloc_addr_o = pool[head_q];
    assign empty_o      = (count_q == '0);

    // ****************************************
    // Pool update
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Every buffer address starts out free, in ascending order.
            for (int i = 0; i < switch_pkg::BUF_DEPTH; i++) begin
                pool[i] <= switch_pkg::ADDR_W'(i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (switch_pkg::ADDR_W + 1)'(switch_pkg::BUF_DEPTH);
        end else begin
            if (free_i) begin
                pool[tail_q] <= free_addr_i;
                tail_q       <= tail_q + 1'b1;
            end
            if (alloc_i) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, free_i})
                2'b10: count_q <= count_q - 1'b1;
                2'b01: count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_i |-> !empty_o);

    // A returned address must have been handed out before.
    a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
        (free_i && !alloc_i) |-> (count_q < switch_pkg::BUF_DEPTH));

endmodule

`default_nettype wire

/* cell_buffer.sv */
`default_nettype none

module cell_buffer (
    input  wire logic                           clk,
    input  wire logic                           wr_en_i,
    input  wire logic [switch_pkg::ADDR_W-1:0]  wr_addr_i,
    input  wire logic [switch_pkg::DATA_W-1:0]  wr_data_i,
    input  wire logic [switch_pkg::ADDR_W-1:0]  rd_addr_i,
    output logic      [switch_pkg::DATA_W-1:0]  rd_data_o
);

    logic [switch_pkg::DATA_W-1:0] mem [switch_pkg::BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // The read is registered, so data appears one cycle after the address.
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

/* egress_sched.sv */
`default_nettype none

module egress_sched (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic [switch_pkg::N_PORTS-1:0]  empty_i,
    input  wire logic [switch_pkg::N_PORTS-1:0]  enable_i,
    output logic      [switch_pkg::N_PORTS-1:0]  grant_o
);

    logic [switch_pkg::N_PORTS-1:0] eligible;
    logic [switch_pkg::PORT_W-1:0]  start_q;
    logic [switch_pkg::PORT_W-1:0]  grant_port;

    assign eligible = enable_i & ~empty_i;

    // ****************************************
    // Rotating priority search
    // ****************************************
    // The search begins at start_q and wraps, since N_PORTS fills the PORT_W range.
    always_comb begin
        logic                          found;
        logic [switch_pkg::PORT_W-1:0] idx;
        found      = 1'b0;
        idx        = '0;
        grant_o    = '0;
        grant_port = start_q;
        for (int k = 0; k < switch_pkg::N_PORTS; k++) begin
            idx = start_q + switch_pkg::PORT_W'(k);
            if (!found && eligible[idx]) begin
                found         = 1'b1;
                grant_o[idx]  = 1'b1;
                grant_port    = idx;
            end
        end
    end

    // Next search starts one past the port just served.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= '0;
        end else if (|grant_o) begin
            start_q <= grant_port + 1'b1;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant_o));

endmodule

`default_nettype wire

/* switch_csr.sv */
`default_nettype none

module switch_csr (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               cfg_we_i,
    input  wire logic [switch_pkg::CSR_ADDR_W-1:0]  cfg_addr_i,
    input  wire logic [switch_pkg::N_PORTS-1:0]     cfg_wdata_i,
    output logic      [switch_pkg::CNT_W-1:0]       cfg_rdata_o,
    input  wire logic                               drop_i,
    input  wire logic [switch_pkg::PORT_W-1:0]      drop_port_i,
    output logic      [switch_pkg::N_PORTS-1:0]     enable_o
);

    logic [switch_pkg::N_PORTS-1:0] enable_q;
    logic [switch_pkg::CNT_W-1:0]   drop_cnt [switch_pkg::N_PORTS];
    logic [switch_pkg::PORT_W-1:0]  rd_port;

    assign enable_o = enable_q;
    assign rd_port  = switch_pkg::PORT_W'(cfg_addr_i - switch_pkg::CSR_DROP_BASE);

    // ****************************************
    // Enable mask
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= '1;
        end else if (cfg_we_i && cfg_addr_i == switch_pkg::CSR_ENABLE) begin
            enable_q <= cfg_wdata_i;
        end
    end

    // ****************************************
    // Drop counters
    // ****************************************
    // Counters stick at their maximum value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
                drop_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
                if (drop_i && drop_port_i == switch_pkg::PORT_W'(p) && drop_cnt[p] != '1) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

    // Unmapped addresses read as zero.
    always_comb begin
        cfg_rdata_o = '0;
        if (cfg_addr_i == switch_pkg::CSR_ENABLE) begin
            cfg_rdata_o = switch_pkg::CNT_W'(enable_q);
        end else if (cfg_addr_i >= switch_pkg::CSR_DROP_BASE) begin
            cfg_rdata_o = drop_cnt[rd_port];
        end
    end

endmodule

`default_nettype wire

/* switch_top.sv */
`default_nettype none

module switch_top (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               cell_valid_i,
    input  wire logic [switch_pkg::PORT_W-1:0]      cell_dest_i,
    input  wire logic [switch_pkg::DATA_W-1:0]      cell_data_i,
    output logic                                    drop_o,
    output logic      [switch_pkg::PORT_W-1:0]      drop_port_o,
    output logic                                    out_valid_o,
    output logic      [switch_pkg::PORT_W-1:0]      out_port_o,
    output logic      [switch_pkg::DATA_W-1:0]      out_data_o,
    input  wire logic                               cfg_we_i,
    input  wire logic [switch_pkg::CSR_ADDR_W-1:0]  cfg_addr_i,
    input  wire logic [switch_pkg::N_PORTS-1:0]     cfg_wdata_i,
    output logic      [switch_pkg::CNT_W-1:0]       cfg_rdata_o
);

    logic [switch_pkg::N_PORTS-1:0] voq_empty;
    logic [switch_pkg::N_PORTS-1:0] voq_full;
    logic [switch_pkg::N_PORTS-1:0] voq_ptr_valid;
    logic [switch_pkg::N_PORTS-1:0] voq_wr_req;
    logic [switch_pkg::N_PORTS-1:0] grant;
    logic [switch_pkg::N_PORTS-1:0] enable;
    logic [switch_pkg::ADDR_W-1:0]  voq_ptr [switch_pkg::N_PORTS];

    logic                          accept;
    logic                          fl_empty;
    logic [switch_pkg::ADDR_W-1:0] alloc_addr;
    logic [switch_pkg::ADDR_W-1:0] egress_addr;
    logic [switch_pkg::PORT_W-1:0] grant_port;
    logic                          s1_valid;
    logic [switch_pkg::PORT_W-1:0] s1_port;

    // ****************************************
    // Ingress
    // ****************************************
    assign accept      = cell_valid_i && !voq_full[cell_dest_i] && !fl_empty;
    assign drop_o      = cell_valid_i && !accept;
    assign drop_port_o = cell_dest_i;

    free_list u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_i      (accept),
        .alloc_addr_o (alloc_addr),
        .free_i       (s1_valid),
        .free_addr_i  (egress_addr),
        .empty_o      (fl_empty)
    );

    cell_buffer u_cell_buffer (
        .clk       (clk),
        .wr_en_i   (accept),
        .wr_addr_i (alloc_addr),
        .wr_data_i (cell_data_i),
        .rd_addr_i (egress_addr),
        .rd_data_o (out_data_o)
    );

    for (genvar p = 0; p < switch_pkg::N_PORTS; p++) begin : g_voq
        assign voq_wr_req[p] = accept && (cell_dest_i == switch_pkg::PORT_W'(p));

        voq u_voq (
            .clk         (clk),
            .rst_n       (rst_n),
            .write_req_i (voq_wr_req[p]),
            .ptr_i       (alloc_addr),
            .read_req_i  (grant[p]),
            .ptr_o       (voq_ptr[p]),
            .ptr_valid_o (voq_ptr_valid[p]),
            .empty_o     (voq_empty[p]),
            .full_o      (voq_full[p])
        );
    end

    // ****************************************
    // Egress
    // ****************************************
    egress_sched u_egress_sched (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty_i  (voq_empty),
        .enable_i (enable),
        .grant_o  (grant)
    );

    switch_csr u_switch_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .drop_i      (drop_o),
        .drop_port_i (drop_port_o),
        .enable_o    (enable)
    );

    always_comb begin
        grant_port = '0;
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            if (grant[p]) begin
                grant_port = switch_pkg::PORT_W'(p);
            end
        end
    end

    // The pointer popped by last cycle's grant addresses the buffer and is recycled.
    assign egress_addr = voq_ptr[s1_port];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            s1_valid    <= |grant;
            out_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_port    <= grant_port;
        out_port_o <= s1_port;
    end

    // The granted VOQ, and only that one, presents its pointer in the next cycle.
    a_ptr_follows_grant: assert property (@(posedge clk) disable iff (!rst_n)
        (|grant) |=> (voq_ptr_valid == $past(grant)));

endmodule

`default_nettype wire

/* tb_switch.sv */
`default_nettype none

module tb_switch;

    // The tests take roughly 300 cycles, so the bound leaves a wide margin.
    localparam int TEST_CYCLES = 300;
    localparam int MAX_CYCLES  = TEST_CYCLES * 6 + 200;

    logic                              clk;
    logic                              rst_n;
    logic                              cell_valid_i;
    logic [switch_pkg::PORT_W-1:0]     cell_dest_i;
    logic [switch_pkg::DATA_W-1:0]     cell_data_i;
    logic                              drop_o;
    logic [switch_pkg::PORT_W-1:0]     drop_port_o;
    logic                              out_valid_o;
    logic [switch_pkg::PORT_W-1:0]     out_port_o;
    logic [switch_pkg::DATA_W-1:0]     out_data_o;
    logic                              cfg_we_i;
    logic [switch_pkg::CSR_ADDR_W-1:0] cfg_addr_i;
    logic [switch_pkg::N_PORTS-1:0]    cfg_wdata_i;
    logic [switch_pkg::CNT_W-1:0]      cfg_rdata_o;

    // Reference model: expected data per output port, in arrival order.
    logic [switch_pkg::DATA_W-1:0]  exp_q [switch_pkg::N_PORTS][$];
    logic [switch_pkg::PORT_W-1:0]  seen_ports [$];
    logic [switch_pkg::N_PORTS-1:0] blocked;
    logic [switch_pkg::N_PORTS-1:0] exp_enable;
    // Port where the next round-robin search starts, one past the port served last.
    logic [switch_pkg::PORT_W-1:0]  rr_next;
    int                             exp_drops [switch_pkg::N_PORTS];
    int                             pass_cnt;
    int                             fail_cnt;
    int                             out_cnt;
    int                             cycle_cnt;

    switch_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cell_valid_i (cell_valid_i),
        .cell_dest_i  (cell_dest_i),
        .cell_data_i  (cell_data_i),
        .drop_o       (drop_o),
        .drop_port_o  (drop_port_o),
        .out_valid_o  (out_valid_o),
        .out_port_o   (out_port_o),
        .out_data_o   (out_data_o),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input logic ok, input string msg);
        assert (ok) begin
            pass_cnt++;
        end else begin
            $display("ERR @%0t: %s", $time, msg);
            fail_cnt++;
        end
    endtask

    // ****************************************
    // Output monitor
    // ****************************************
    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n && out_valid_o) begin
            out_cnt++;
            seen_ports.push_back(out_port_o);
            check(!blocked[out_port_o], $sformatf("output on disabled port %0d", out_port_o));
            if (exp_q[out_port_o].size() == 0) begin
                check(1'b0, $sformatf("unexpected cell %h on port %0d", out_data_o, out_port_o));
            end else begin
                check(out_data_o == exp_q[out_port_o][0],
                      $sformatf("port %0d data %h, expected %h",
                                out_port_o, out_data_o, exp_q[out_port_o][0]));
                void'(exp_q[out_port_o].pop_front());
            end
        end
    end

    function automatic int pending_cells();
        int n;
        n = 0;
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            if (!blocked[p]) begin
                n += exp_q[p].size();
            end
        end
        return n;
    endfunction

    // ****************************************
    // Stimulus tasks
    // ****************************************
    // A disabled port with a full VOQ must drop the cell.
    task automatic send_cell(input int port);
        logic [switch_pkg::DATA_W-1:0] data;
        logic                          expect_drop;
        data        = switch_pkg::DATA_W'($urandom());
        expect_drop = blocked[port] && (exp_q[port].size() >= switch_pkg::VOQ_DEPTH);
        @(negedge clk);
        cell_valid_i = 1'b1;
        cell_dest_i  = switch_pkg::PORT_W'(port);
        cell_data_i  = data;
        #10;
        check(drop_o == expect_drop,
              $sformatf("drop_o %0b for port %0d, expected %0b", drop_o, port, expect_drop));
        if (expect_drop) begin
            check(drop_port_o == switch_pkg::PORT_W'(port),
                  $sformatf("drop_port_o %0d, expected %0d", drop_port_o, port));
            exp_drops[port]++;
        end else begin
            exp_q[port].push_back(data);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            cell_valid_i = 1'b0;
            cfg_we_i     = 1'b0;
        end
    endtask

    task automatic write_enable(input logic [switch_pkg::N_PORTS-1:0] mask);
        @(negedge clk);
        cell_valid_i = 1'b0;
        cfg_we_i     = 1'b1;
        cfg_addr_i   = switch_pkg::CSR_ENABLE;
        cfg_wdata_i  = mask;
        @(negedge clk);
        cfg_we_i   = 1'b0;
        exp_enable = mask;
    endtask

    task automatic expect_csr(input logic [switch_pkg::CSR_ADDR_W-1:0] addr,
                              input logic [switch_pkg::CNT_W-1:0]      exp_val);
        @(negedge clk);
        cell_valid_i = 1'b0;
        cfg_addr_i   = addr;
        #10;
        check(cfg_rdata_o == exp_val,
              $sformatf("register %0d reads %h, expected %h", addr, cfg_rdata_o, exp_val));
    endtask

    task automatic check_regs();
        expect_csr(switch_pkg::CSR_ENABLE, switch_pkg::CNT_W'(exp_enable));
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            expect_csr(switch_pkg::CSR_DROP_BASE + switch_pkg::CSR_ADDR_W'(p),
                       switch_pkg::CNT_W'(exp_drops[p]));
        end
    endtask

    task automatic wait_drain();
        idle(1);
        while (pending_cells() != 0) begin
            @(posedge clk);
        end
        idle(3);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%-20s finished, %0d errors", name, fail_cnt - fails_before);
    endtask

    // ****************************************
    // Directed tests
    // ****************************************
    task automatic test_reset_state();
        int f0;
        f0 = fail_cnt;
        repeat (5) begin
            @(negedge clk);
            #10;
            check(!drop_o && !out_valid_o, "drop_o or out_valid_o high after reset");
        end
        check_regs();
        report_test("reset state", f0);
    endtask

    task automatic test_single_cells();
        int f0;
        int n0;
        f0 = fail_cnt;
        n0 = out_cnt;
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            send_cell(p);
            wait_drain();
            rr_next = switch_pkg::PORT_W'(p + 1);
        end
        check(out_cnt - n0 == switch_pkg::N_PORTS,
              $sformatf("%0d cells left, expected %0d", out_cnt - n0, switch_pkg::N_PORTS));
        report_test("single cells", f0);
    endtask

    task automatic test_port_order();
        int f0;
        int n0;
        f0 = fail_cnt;
        n0 = out_cnt;
        repeat (4) begin
            send_cell(1);
        end
        wait_drain();
        // Only port 1 was served, so the search moves on to port 2.
        rr_next = switch_pkg::PORT_W'(2);
        check(out_cnt - n0 == 4, $sformatf("%0d cells left port 1, expected 4", out_cnt - n0));
        report_test("port order", f0);
    endtask

    task automatic test_round_robin();
        int                            f0;
        int                            s0;
        logic [switch_pkg::PORT_W-1:0] first;
        f0    = fail_cnt;
        first = rr_next;
        // Hold every queue until two cells wait on each port.
        write_enable('0);
        repeat (2) begin
            for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
                send_cell(p);
            end
        end
        idle(2);
        s0 = seen_ports.size();
        write_enable('1);
        wait_drain();
        check(seen_ports.size() - s0 == 8,
              $sformatf("%0d cells left, expected 8", seen_ports.size() - s0));
        if (seen_ports.size() - s0 == 8) begin
            for (int i = 0; i < 8; i++) begin
                check(seen_ports[s0 + i] == first + switch_pkg::PORT_W'(i),
                      $sformatf("output %0d on port %0d, expected %0d", i,
                                seen_ports[s0 + i], first + switch_pkg::PORT_W'(i)));
            end
        end
        report_test("round robin", f0);
    endtask

    task automatic test_disabled_port();
        int f0;
        int n0;
        f0 = fail_cnt;
        write_enable(4'b1011);
        blocked[2] = 1'b1;
        repeat (3) begin
            send_cell(2);
        end
        send_cell(1);
        wait_drain();
        idle(10);
        check(exp_q[2].size() == 3, "cells for disabled port 2 left the switch");
        n0 = out_cnt;
        write_enable(4'b1111);
        blocked[2] = 1'b0;
        wait_drain();
        check(out_cnt - n0 == 3,
              $sformatf("%0d cells left after enable, expected 3", out_cnt - n0));
        report_test("disabled port", f0);
    endtask

    task automatic test_drop_count();
        int f0;
        f0 = fail_cnt;
        write_enable(4'b0111);
        blocked[3] = 1'b1;
        // Four cells fill the VOQ and the last two are dropped.
        repeat (switch_pkg::VOQ_DEPTH + 2) begin
            send_cell(3);
        end
        send_cell(0);
        wait_drain();
        check(exp_q[3].size() == switch_pkg::VOQ_DEPTH, "port 3 VOQ does not hold four cells");
        check_regs();
        write_enable(4'b1111);
        blocked[3] = 1'b0;
        wait_drain();
        report_test("drop count", f0);
    endtask

    initial begin
        void'($urandom(32'h0b2c_6bde));
        clk          = 1'b0;
        rst_n        = 1'b0;
        cell_valid_i = 1'b0;
        cell_dest_i  = '0;
        cell_data_i  = '0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = '0;
        cfg_wdata_i  = '0;
        blocked      = '0;
        exp_enable   = '1;
        rr_next      = '0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        out_cnt      = 0;
        cycle_cnt    = 0;
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            exp_drops[p] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_single_cells();
        test_port_order();
        test_round_robin();
        test_disabled_port();
        test_drop_count();
        idle(5);

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
switch_pkg.sv
voq.sv
free_list.sv
cell_buffer.sv
egress_sched.sv
switch_csr.sv
switch_top.sv
tb_switch.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the switch testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_switch \
    -Mdir obj_dir -o tb_switch
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_switch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
